/* sysarr_accum.f */
+incdir+design
design/fp16_pkg.sv
design/accum_pkg.sv
design/fp16_add_pipe.sv
design/accum_lane.sv
design/wb_arbiter.sv
design/psum_mem.sv
design/sysarr_accum_top.sv
verif/sysarr_accum_assertions.sv
verif/sysarr_accum_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= sysarr_accum_tb
FLIST     ?= sysarr_accum.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps -j 0

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "RESULT: PASS"

clean:
	rm -rf $(OBJ_DIR)

/* verif/sysarr_accum_tb.sv */
`timescale 1ns/1ps

`include "sysarr_cfg.svh"

module sysarr_accum_tb;
    import fp16_pkg::*;
    import accum_pkg::*;

    localparam int TMO = 200;   // cycles allowed for any single wait

    logic       clk;
    logic       nRST;
    logic       req_valid [`SYSARR_NUM_LANES];
    accum_req_t req       [`SYSARR_NUM_LANES];
    logic       req_ready [`SYSARR_NUM_LANES];
    logic       done      [`SYSARR_NUM_LANES];
    fp16_t      result    [`SYSARR_NUM_LANES];
    fp16_t      lane_res  [`SYSARR_NUM_LANES];   // value seen with the last done
    int         model     [`SYSARR_MEM_DEPTH];   // integer total per address
    integer     seed;

    sysarr_accum_top DUT (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic check_value(input string what, input logic [15:0] got,
                               input logic [15:0] expect_val);
        assert (got === expect_val) else begin
            $display("[ERROR] %0t: %s got %h expected %h", $time, what, got, expect_val);
            $display("RESULT: FAIL");
            $fatal(1);
        end
    endtask

    // exact half precision pattern of an integer below 2048 in magnitude
    function automatic fp16_t int_to_fp16(input int v);
        int    m;
        int    p;
        fp16_t f;
        m = (v < 0) ? -v : v;
        p = 0;
        f = '0;
        if (m != 0) begin
            for (int i = 0; i < 11; i++) begin
                if ((m >> i) != 0) p = i;
            end
            f.sign = (v < 0);
            f.exp  = 5'(p + 15);
            f.frac = 10'((m << (10 - p)) & 'h3ff);   // hidden bit drops out
        end
        return f;
    endfunction

    task automatic request(input int lane, input accum_op_e op, input int adr, input fp16_t value);
        int n;
        @(negedge clk);
        req_valid[lane] = 1'b1;
        req[lane]       = '{op: op, adr: adr[`SYSARR_ADDR_W-1:0], value: value};
        n = 0;
        while (!req_ready[lane] && n < TMO) begin
            @(negedge clk);
            n++;
        end
        if (!req_ready[lane]) begin
            $display("timeout: lane %0d never accepted its request", lane);
            $display("RESULT: FAIL");
            $fatal(1);
        end
        @(negedge clk);   // taken on the rising edge in between
        req_valid[lane] = 1'b0;
    endtask

    task automatic wait_done(input int lane);
        int n;
        n = 0;
        while (!done[lane] && n < TMO) begin
            @(negedge clk);
            n++;
        end
        if (!done[lane]) begin
            $display("timeout: lane %0d never signalled done", lane);
            $display("RESULT: FAIL");
            $fatal(1);
        end
        lane_res[lane] = result[lane];
    endtask

    task automatic op_and_check(input int lane, input accum_op_e op, input int adr,
                                input fp16_t value, input fp16_t expect_val, input string what);
        request(lane, op, adr, value);
        wait_done(lane);
        check_value(what, lane_res[lane], expect_val);
    endtask

    task automatic test_reset();
        for (int i = 0; i < `SYSARR_NUM_LANES; i++) begin
            check_value("req_ready after reset", {15'd0, req_ready[i]}, 16'd1);
            check_value("done after reset", {15'd0, done[i]}, 16'd0);
        end
    endtask

    task automatic test_load_add();
        op_and_check(0, ACC_LOAD, 0, 16'h3e00, 16'h3e00, "load 1.5");
        op_and_check(0, ACC_ADD, 0, 16'h4080, 16'h4380, "1.5 + 2.25");
        op_and_check(0, ACC_ADD, 0, 16'h0000, 16'h4380, "readback of 3.75");
        op_and_check(0, ACC_LOAD, 0, 16'h3c00, 16'h3c00, "load 1.0");
        op_and_check(0, ACC_ADD, 0, 16'h1000, 16'h3c00, "1.0 + 2^-11");   // below one ulp
    endtask

    task automatic test_signs();
        op_and_check(1, ACC_LOAD, 1, 16'h4200, 16'h4200, "load 3.0");
        op_and_check(1, ACC_ADD, 1, 16'hc200, 16'h0000, "3.0 - 3.0");
        op_and_check(1, ACC_LOAD, 2, 16'h4800, 16'h4800, "load 8.0");
        op_and_check(1, ACC_ADD, 2, 16'hb800, 16'h4780, "8.0 - 0.5");
        op_and_check(0, ACC_LOAD, 3, 16'hb400, 16'hb400, "load -0.25");
        // ulp is 0.5 here, so 1023.75 truncates to 1023.5
        op_and_check(0, ACC_ADD, 3, 16'h6400, 16'h63ff, "-0.25 + 1024");
    endtask

    task automatic test_overflow();
        op_and_check(1, ACC_LOAD, 4, 16'h7b53, 16'h7b53, "load 60000");
        op_and_check(1, ACC_ADD, 4, 16'h7b53, 16'h7c00, "60000 + 60000");
        op_and_check(0, ACC_LOAD, 5, 16'hfb53, 16'hfb53, "load -60000");
        op_and_check(0, ACC_ADD, 5, 16'hfb53, 16'h7c00, "-60000 - 60000");
    endtask

    task automatic test_contention();
        logic ok;
        op_and_check(0, ACC_LOAD, 6, int_to_fp16(100), int_to_fp16(100), "load 100");
        fork
            begin
                request(0, ACC_ADD, 6, int_to_fp16(7));
                wait_done(0);
            end
            begin
                request(1, ACC_ADD, 6, int_to_fp16(9));
                wait_done(1);
            end
        join
        // either lane may win, the loser must build on the winner's sum
        ok = (lane_res[0] == int_to_fp16(107) && lane_res[1] == int_to_fp16(116))
          || (lane_res[1] == int_to_fp16(109) && lane_res[0] == int_to_fp16(116));
        check_value("results of two adds on one address", {15'd0, ok}, 16'd1);
        op_and_check(1, ACC_ADD, 6, 16'h0000, int_to_fp16(116), "readback after contention");
    endtask

    task automatic test_random();
        int lane;
        int adr;
        int v;
        seed = 32'h89c7;
        for (int a = 0; a < `SYSARR_MEM_DEPTH; a++) begin
            v        = $random(seed) % 65;
            model[a] = v;
            op_and_check(a % `SYSARR_NUM_LANES, ACC_LOAD, a, int_to_fp16(v), int_to_fp16(v),
                         "random load");
        end
        for (int k = 0; k < 30; k++) begin
            lane       = $unsigned($random(seed)) % `SYSARR_NUM_LANES;
            adr        = $unsigned($random(seed)) % `SYSARR_MEM_DEPTH;
            v          = $random(seed) % 65;   // -64 to 64
            model[adr] = model[adr] + v;
            op_and_check(lane, ACC_ADD, adr, int_to_fp16(v), int_to_fp16(model[adr]),
                         "random add");
        end
        for (int a = 0; a < `SYSARR_MEM_DEPTH; a++) begin
            op_and_check(a % `SYSARR_NUM_LANES, ACC_ADD, a, 16'h0000, int_to_fp16(model[a]),
                         "final readback");
        end
    endtask

    initial begin
        nRST = 1'b0;
        for (int i = 0; i < `SYSARR_NUM_LANES; i++) begin
            req_valid[i] = 1'b0;
            req[i]       = '0;
        end
        repeat (16) @(posedge clk);
        @(negedge clk);
        nRST = 1'b1;
        test_reset();
        test_load_add();
        test_signs();
        test_overflow();
        test_contention();
        test_random();
        $display("RESULT: PASS");
        $finish;
    end

endmodule

/* verif/sysarr_accum_assertions.sv */
`timescale 1ns/1ps

`include "sysarr_cfg.svh"

module sysarr_accum_assertions (
    input logic               clk,
    input logic               nRST,
    input accum_pkg::wb_m2s_t mem_m2s,
    input accum_pkg::wb_s2m_t mem_s2m,
    input logic               req_ready [`SYSARR_NUM_LANES],
    input logic               done      [`SYSARR_NUM_LANES]
);
    // memory side of the arbiter
    a_mem_stb_cyc: assert property (@(posedge clk) disable iff (!nRST)
        mem_m2s.stb |-> mem_m2s.cyc) else $error("stb without cyc at the memory");

    a_ack_qual: assert property (@(posedge clk) disable iff (!nRST)
        mem_s2m.ack |-> (mem_m2s.cyc && mem_m2s.stb)) else $error("ack outside a strobe");

    a_ack_single: assert property (@(posedge clk) disable iff (!nRST)
        mem_s2m.ack |=> !mem_s2m.ack) else $error("ack longer than one cycle");

    for (genvar g = 0; g < `SYSARR_NUM_LANES; g++) begin : g_lane
        a_done_pulse: assert property (@(posedge clk) disable iff (!nRST)
            done[g] |=> !done[g]) else $error("done longer than one cycle");

        a_ready_done: assert property (@(posedge clk) disable iff (!nRST)
            !(req_ready[g] && done[g])) else $error("req_ready and done together");
    end

endmodule

bind sysarr_accum_top sysarr_accum_assertions u_assert (
    .clk(clk), .nRST(nRST), .mem_m2s(mem_m2s),
    .mem_s2m(mem_s2m), .req_ready(req_ready), .done(done)
);

/* design/sysarr_accum_top.sv */
`timescale 1ns/1ps

`include "sysarr_cfg.svh"

module sysarr_accum_top (
    input  logic                  clk,
    input  logic                  nRST,
    input  logic                  req_valid [`SYSARR_NUM_LANES],
    input  accum_pkg::accum_req_t req       [`SYSARR_NUM_LANES],
    output logic                  req_ready [`SYSARR_NUM_LANES],
    output logic                  done      [`SYSARR_NUM_LANES],
    output fp16_pkg::fp16_t       result    [`SYSARR_NUM_LANES]
);
    import fp16_pkg::*;
    import accum_pkg::*;

    wb_m2s_t lane_m2s [`SYSARR_NUM_LANES];
    wb_s2m_t lane_s2m [`SYSARR_NUM_LANES];
    wb_m2s_t mem_m2s;
    wb_s2m_t mem_s2m;

    // private adder per lane
    logic    add_valid     [`SYSARR_NUM_LANES];
    logic    add_out_valid [`SYSARR_NUM_LANES];
    fp16_t   add_a         [`SYSARR_NUM_LANES];
    fp16_t   add_b         [`SYSARR_NUM_LANES];
    fp16_t   add_sum       [`SYSARR_NUM_LANES];

    for (genvar g = 0; g < `SYSARR_NUM_LANES; g++) begin : g_lane
        accum_lane u_lane (
            .clk(clk), .nRST(nRST),
            .req_valid(req_valid[g]), .req(req[g]),
            .wb_in(lane_s2m[g]),
            .add_out_valid(add_out_valid[g]), .add_sum(add_sum[g]),
            .req_ready(req_ready[g]), .done(done[g]), .result(result[g]),
            .wb_out(lane_m2s[g]),
            .add_valid(add_valid[g]), .add_a(add_a[g]), .add_b(add_b[g])
        );

        fp16_add_pipe u_add (
            .clk(clk), .nRST(nRST),
            .in_valid(add_valid[g]), .a(add_a[g]), .b(add_b[g]),
            .out_valid(add_out_valid[g]), .sum(add_sum[g])
        );
    end

    wb_arbiter u_arb (
        .clk(clk), .nRST(nRST),
        .m_in(lane_m2s), .s_in(mem_s2m),
        .m_out(lane_s2m), .s_out(mem_m2s)
    );

    psum_mem u_mem (.clk(clk), .nRST(nRST), .wb_in(mem_m2s), .wb_out(mem_s2m));

endmodule

/* design/psum_mem.sv */
`timescale 1ns/1ps

`include "sysarr_cfg.svh"

module psum_mem (
    input  logic               clk,
    input  logic               nRST,
    input  accum_pkg::wb_m2s_t wb_in,
    output accum_pkg::wb_s2m_t wb_out
);
    import fp16_pkg::*;

    fp16_t mem [`SYSARR_MEM_DEPTH];   // partial sums
    fp16_t rdata_q;
    logic  ack_q;
    logic  take;

    // a new access is seen only while no ack is outstanding
    assign take = wb_in.cyc && wb_in.stb && !ack_q;

    always_ff @(posedge clk, negedge nRST) begin
        if (!nRST) begin
            ack_q <= 1'b0;
        end else begin
            ack_q <= take;   // single cycle, stb drops after it
        end
    end

    // access lands on the same edge that raises ack
    always_ff @(posedge clk) begin
        if (take) begin
            if (wb_in.we) mem[wb_in.adr] <= wb_in.dat;
            rdata_q <= mem[wb_in.adr];
        end
    end

    assign wb_out.ack = ack_q;
    assign wb_out.dat = rdata_q;

endmodule

/* design/wb_arbiter.sv */
`timescale 1ns/1ps

`include "sysarr_cfg.svh"

module wb_arbiter (
    input  logic               clk,
    input  logic               nRST,
    input  accum_pkg::wb_m2s_t m_in  [`SYSARR_NUM_LANES],
    input  accum_pkg::wb_s2m_t s_in,
    output accum_pkg::wb_s2m_t m_out [`SYSARR_NUM_LANES],
    output accum_pkg::wb_m2s_t s_out
);
    localparam int IDX_W = ($clog2(`SYSARR_NUM_LANES) > 0) ? $clog2(`SYSARR_NUM_LANES) : 1;

    logic [IDX_W-1:0] owner, next_owner;   // owner is kept as the last winner when idle
    logic             gnt_valid, next_found;

    // first requester after the last owner
    always_comb begin
        int cand;
        next_owner = owner;
        next_found = 1'b0;
        for (int i = 1; i <= `SYSARR_NUM_LANES; i++) begin
            cand = (int'(owner) + i) % `SYSARR_NUM_LANES;
            if (!next_found && m_in[cand].cyc) begin
                next_found = 1'b1;
                next_owner = IDX_W'(cand);
            end
        end
    end

    always_ff @(posedge clk, negedge nRST) begin
        if (!nRST) begin
            gnt_valid <= 1'b0;
            owner     <= '0;
        end else if (!gnt_valid || !m_in[owner].cyc) begin   // bus free or being released
            gnt_valid <= next_found;
            if (next_found) owner <= next_owner;
        end
    end

    always_comb begin
        s_out = m_in[owner];
        if (!gnt_valid) begin
            s_out.cyc = 1'b0;
            s_out.stb = 1'b0;
        end
        for (int i = 0; i < `SYSARR_NUM_LANES; i++) begin
            m_out[i].dat = s_in.dat;
            m_out[i].ack = s_in.ack && gnt_valid && (owner == IDX_W'(i));
        end
    end

endmodule

/* design/accum_lane.sv */
`timescale 1ns/1ps

module accum_lane (
    input  logic                   clk,
    input  logic                   nRST,
    input  logic                   req_valid,
    input  accum_pkg::accum_req_t  req,
    input  accum_pkg::wb_s2m_t     wb_in,
    input  logic                   add_out_valid,
    input  fp16_pkg::fp16_t        add_sum,
    output logic                   req_ready,
    output logic                   done,
    output fp16_pkg::fp16_t        result,
    output accum_pkg::wb_m2s_t     wb_out,
    output logic                   add_valid,
    output fp16_pkg::fp16_t        add_a,
    output fp16_pkg::fp16_t        add_b
);
    import fp16_pkg::*;
    import accum_pkg::*;

    lane_state_e state, state_n;
    accum_req_t  req_q;    // request under service
    fp16_t       wdata;    // value to write back

    always_ff @(posedge clk, negedge nRST) begin
        if (!nRST) begin
            state <= IDLE;
        end else begin
            state <= state_n;
        end
    end

    always_comb begin
        state_n = state;
        case (state)
            IDLE: begin
                if (req_valid) state_n = (req.op == ACC_LOAD) ? WRITE : READ;
            end
            READ: begin
                if (wb_in.ack) state_n = ADD_WAIT;
            end
            ADD_WAIT: begin
                if (add_out_valid) state_n = WRITE;
            end
            WRITE: begin
                if (wb_in.ack) state_n = DONE;
            end
            DONE:    state_n = IDLE;
            default: state_n = IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (req_valid && req_ready) req_q <= req;
        if (state == IDLE && req_valid && req.op == ACC_LOAD) begin
            wdata <= req.value;   // load skips the read
        end else if (state == ADD_WAIT && add_out_valid) begin
            wdata <= add_sum;
        end
    end

    // cyc stays up from read to write so nobody else touches the word
    always_comb begin
        wb_out.cyc = (state == READ) || (state == ADD_WAIT) || (state == WRITE);
        wb_out.stb = (state == READ) || (state == WRITE);
        wb_out.we  = (state == WRITE);
        wb_out.adr = req_q.adr;
        wb_out.dat = wdata;
    end

    // stored word goes straight into the adder on the read ack
    assign add_valid = (state == READ) && wb_in.ack;
    assign add_a     = wb_in.dat;
    assign add_b     = req_q.value;

    assign req_ready = (state == IDLE);
    assign done      = (state == DONE);
    assign result    = wdata;   // held through DONE

endmodule

/* design/fp16_add_pipe.sv */
`timescale 1ns/1ps

module fp16_add_pipe (
    input  logic            clk,
    input  logic            nRST,
    input  logic            in_valid,
    input  fp16_pkg::fp16_t a,
    input  fp16_pkg::fp16_t b,
    output logic            out_valid,
    output fp16_pkg::fp16_t sum
);
    import fp16_pkg::*;

    add_align_t  align_d, s1;
    add_sum_t    sum_d, s2;
    fp16_t       res_d;
    logic        s1_valid, s2_valid;
    logic [12:0] a_sig, b_sig, small_sig;
    logic        a_sgn, b_sgn;
    logic [4:0]  diff, shamt;
    logic [25:0] ext;
    logic        sticky;
    logic [3:0]  lead, shift;
    logic [12:0] norm;

    // position of the highest set bit, 0 when v is zero
    function automatic logic [3:0] lead_one(input logic [12:0] v);
        logic [3:0] pos;
        pos = 4'd0;
        for (int i = 0; i < 13; i++) begin
            if (v[i]) pos = 4'(i);
        end
        return pos;
    endfunction

    // stage 1: flush subnormals, order by exponent, align the smaller one
    always_comb begin
        a_sig = (a.exp == 5'd0) ? 13'd0 : {1'b1, a.frac, 2'b00};
        b_sig = (b.exp == 5'd0) ? 13'd0 : {1'b1, b.frac, 2'b00};
        a_sgn = (a.exp == 5'd0) ? 1'b0 : a.sign;   // flushed value is +0
        b_sgn = (b.exp == 5'd0) ? 1'b0 : b.sign;
        if (a.exp >= b.exp) begin
            align_d.sign_big   = a_sgn;
            align_d.sign_small = b_sgn;
            align_d.sig_big    = a_sig;
            align_d.exp_max    = a.exp;
            small_sig          = b_sig;
            diff               = a.exp - b.exp;
        end else begin
            align_d.sign_big   = b_sgn;
            align_d.sign_small = a_sgn;
            align_d.sig_big    = b_sig;
            align_d.exp_max    = b.exp;
            small_sig          = a_sig;
            diff               = b.exp - a.exp;
        end
        shamt  = (diff > 5'd13) ? 5'd13 : diff;   // past 13 every bit is gone
        ext    = {small_sig, 13'd0} >> shamt;
        sticky = |ext[12:0];
        // on subtraction lost bits bump the subtrahend so truncation stays toward zero
        align_d.sig_small = ext[25:13]
                          + {12'd0, sticky & (align_d.sign_big ^ align_d.sign_small)};
    end

    // stage 2: magnitude add or subtract
    always_comb begin
        sum_d.exp = s1.exp_max;
        if (s1.sign_big == s1.sign_small) begin
            {sum_d.carry, sum_d.sig} = {1'b0, s1.sig_big} + {1'b0, s1.sig_small};
            sum_d.sign = s1.sign_big;
        end else if (s1.sig_big >= s1.sig_small) begin
            sum_d.carry = 1'b0;
            sum_d.sig   = s1.sig_big - s1.sig_small;
            sum_d.sign  = s1.sign_big;
        end else begin
            sum_d.carry = 1'b0;   // equal exponents, b side larger
            sum_d.sig   = s1.sig_small - s1.sig_big;
            sum_d.sign  = s1.sign_small;
        end
    end

    // stage 3: normalize and truncate
    always_comb begin
        lead  = lead_one(s2.sig);
        shift = 4'd12 - lead;
        norm  = s2.sig << shift;
        if (s2.carry) begin
            if (s2.exp >= 5'd30) res_d = FP16_POS_INF;
            else res_d = '{sign: s2.sign, exp: s2.exp + 5'd1, frac: s2.sig[12:3]};
        end else if (s2.sig == 13'd0 || s2.exp <= {1'b0, shift}) begin
            res_d = '0;   // cancellation or underflow
        end else begin
            res_d = '{sign: s2.sign, exp: s2.exp - {1'b0, shift}, frac: norm[11:2]};
        end
    end

    always_ff @(posedge clk, negedge nRST) begin
        if (!nRST) begin
            s1_valid  <= 1'b0;
            s2_valid  <= 1'b0;
            out_valid <= 1'b0;
        end else begin
            s1_valid  <= in_valid;
            s2_valid  <= s1_valid;
            out_valid <= s2_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid) s1 <= align_d;
        if (s1_valid) s2 <= sum_d;
        if (s2_valid) sum <= res_d;
    end

endmodule

/* design/accum_pkg.sv */
`include "sysarr_cfg.svh"

package accum_pkg;

    // wishbone classic, master to slave
    typedef struct packed {
        logic                      cyc;
        logic                      stb;
        logic                      we;
        logic [`SYSARR_ADDR_W-1:0] adr;
        fp16_pkg::fp16_t           dat;
    } wb_m2s_t;

    // slave to master
    typedef struct packed {
        logic            ack;
        fp16_pkg::fp16_t dat;
    } wb_s2m_t;

    typedef enum logic {
        ACC_ADD  = 1'b0,   // stored + value
        ACC_LOAD = 1'b1    // stored = value
    } accum_op_e;

    typedef struct packed {
        accum_op_e                 op;
        logic [`SYSARR_ADDR_W-1:0] adr;
        fp16_pkg::fp16_t           value;
    } accum_req_t;

    typedef enum logic [2:0] {IDLE, READ, ADD_WAIT, WRITE, DONE} lane_state_e;

endpackage

/* design/fp16_pkg.sv */
package fp16_pkg;

    // IEEE half precision word
    typedef struct packed {
        logic       sign;
        logic [4:0] exp;   // biased by 15
        logic [9:0] frac;
    } fp16_t;

    // overflow result, sign is dropped on purpose
    localparam fp16_t FP16_POS_INF = '{sign: 1'b0, exp: 5'h1f, frac: 10'd0};

    // stage one to stage two of the adder
    // significands are {hidden, frac, 2 guard bits}
    typedef struct packed {
        logic        sign_big;    // operand with the larger exponent
        logic        sign_small;
        logic [12:0] sig_big;
        logic [12:0] sig_small;   // already shifted right by the exponent gap
        logic [4:0]  exp_max;
    } add_align_t;

    // stage two to stage three of the adder
    typedef struct packed {
        logic        sign;
        logic [12:0] sig;
        logic        carry;       // sum spilled past the hidden bit
        logic [4:0]  exp;
    } add_sum_t;

endpackage

/* design/sysarr_cfg.svh */
`ifndef SYSARR_CFG_SVH
`define SYSARR_CFG_SVH

// geometry of the accumulation stage

`define SYSARR_NUM_LANES 2   // accumulator lanes sharing one memory

// word address into the partial-sum array
`define SYSARR_ADDR_W 4

`define SYSARR_MEM_DEPTH 16  // 2**SYSARR_ADDR_W words

`endif
